// ==== filelist.f ====
+incdir+src
src/mem_addr_pkg.sv
src/mem_txn_pkg.sv
src/bank_port_if.sv
src/sram_bank.sv
src/bank_arbiter.sv
src/narrow_router.sv
src/wide_splitter_fsm.sv
src/mem_island_top.sv
tb/mem_island_assert.sv
tb/mem_island_tb.sv

// ==== tb/mem_island_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratchpad testbench
// Narrow and wide traffic checked against a byte model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module mem_island_tb;

  localparam int TIMEOUT = 200;

  logic                       clk_i = 1'b0;
  logic                       rst_ni = 1'b0;
  logic                       narrow_req_i = 1'b0;
  logic                       narrow_we_i = 1'b0;
  logic                       wide_req_i = 1'b0;
  logic                       wide_we_i = 1'b0;
  logic                       narrow_gnt_o;
  logic                       narrow_rvalid_o;
  logic                       wide_gnt_o;
  logic                       wide_rvalid_o;
  mem_addr_pkg::addr_t        narrow_addr_i = '0;
  mem_addr_pkg::addr_t        wide_addr_i = '0;
  mem_addr_pkg::narrow_data_t narrow_wdata_i = '0;
  mem_addr_pkg::narrow_data_t narrow_rdata_o;
  mem_addr_pkg::narrow_strb_t narrow_strb_i = '0;
  mem_addr_pkg::wide_data_t   wide_wdata_i = '0;
  mem_addr_pkg::wide_data_t   wide_rdata_o;
  mem_addr_pkg::wide_strb_t   wide_strb_i = '0;

  // Byte image of the 4 KiB island
  logic [7:0]  ref_mem [4096];
  // Expected narrow responses in request order, write flag on top
  logic [32:0] exp_q [$];
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_errs = 0;
  int          assert_errs = 0;
  int          wide_issued = 0;
  int          wide_seen = 0;
  integer      seed = 32'h8e5e;

  mem_island_top i_mem_island_top (.*);

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  // Narrow data lands in bits 31:0, wide covers the aligned 8-byte block
  function automatic mem_addr_pkg::wide_data_t ref_read(input mem_addr_pkg::addr_t addr,
                                                        input logic wide);
    mem_addr_pkg::wide_data_t data;
    int base;
    data = '0;
    base = wide ? {addr[11:3], 3'b000} : {addr[11:2], 2'b00};
    for (int b = 0; b < (wide ? 8 : 4); b++) begin
      data[b*8 +: 8] = ref_mem[base + b];
    end
    return data;
  endfunction

  function automatic void ref_write(input mem_addr_pkg::addr_t addr, input logic wide,
                                    input mem_addr_pkg::wide_data_t data,
                                    input mem_addr_pkg::wide_strb_t strb);
    int base;
    base = wide ? {addr[11:3], 3'b000} : {addr[11:2], 2'b00};
    for (int b = 0; b < (wide ? 8 : 4); b++) begin
      if (strb[b]) begin
        ref_mem[base + b] = data[b*8 +: 8];
      end
    end
  endfunction

  task automatic check_narrow(input mem_addr_pkg::narrow_data_t got, exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERROR narrow_rdata_o got 0x%h expected 0x%h", got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_wide(input mem_addr_pkg::wide_data_t got, exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERROR wide_rdata_o got 0x%h expected 0x%h", got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_grant(input logic got, exp);
    check_cnt++;
    if (got !== exp) begin
      $display("ERROR narrow_gnt_o got 0x%h expected 0x%h", got, exp);
      err_cnt++;
    end
  endtask

  // Narrow gnt follows req, so the access is taken at the next edge
  task automatic narrow_access(input mem_addr_pkg::addr_t addr, input logic we,
                               input mem_addr_pkg::narrow_data_t wdata,
                               input mem_addr_pkg::narrow_strb_t strb);
    narrow_req_i   = 1'b1;
    narrow_addr_i  = addr;
    narrow_we_i    = we;
    narrow_wdata_i = wdata;
    narrow_strb_i  = strb;
    exp_q.push_back({we, mem_addr_pkg::narrow_data_t'(ref_read(addr, 1'b0))});
    if (we) begin
      ref_write(addr, 1'b0, {32'h0, wdata}, {4'h0, strb});
    end
    @(negedge clk_i);
  endtask

  task automatic wide_access(input mem_addr_pkg::addr_t addr, input logic we,
                             input mem_addr_pkg::wide_data_t wdata,
                             input mem_addr_pkg::wide_strb_t strb);
    wide_req_i   = 1'b1;
    wide_addr_i  = addr;
    wide_we_i    = we;
    wide_wdata_i = wdata;
    wide_strb_i  = strb;
    #1;
    for (int t = 0; t < TIMEOUT && !wide_gnt_o; t++) begin
      @(negedge clk_i);
      #1;
    end
    if (!wide_gnt_o) begin
      $display("Wide request to 0x%h was never granted", addr);
      err_cnt++;
    end else begin
      wide_issued++;
      if (we) begin
        ref_write(addr, 1'b1, wdata, strb);
      end
    end
    @(negedge clk_i);
    wide_req_i = 1'b0;
    for (int t = 0; t < TIMEOUT && !wide_rvalid_o; t++) begin
      @(negedge clk_i);
    end
    // Expected data is taken at response time, after any narrow writes that won
    if (!wide_rvalid_o) begin
      $display("Wide response for 0x%h timed out", addr);
      err_cnt++;
    end else if (!we) begin
      check_wide(wide_rdata_o, ref_read(addr, 1'b1));
    end
  endtask

  task automatic end_test(input string name);
    narrow_req_i = 1'b0;
    for (int t = 0;
         t < TIMEOUT && (exp_q.size() != 0 || wide_seen != wide_issued);
         t++) begin
      @(negedge clk_i);
    end
    if (exp_q.size() != 0 || wide_seen != wide_issued) begin
      $display("Responses missing at the end of %s", name);
      err_cnt++;
      exp_q.delete();
      wide_seen = wide_issued;
    end
    if (i_mem_island_top.i_mem_island_assert.fail_cnt != assert_errs) begin
      $display("Port protocol assertion failed during %s", name);
      err_cnt += i_mem_island_top.i_mem_island_assert.fail_cnt - assert_errs;
      assert_errs = i_mem_island_top.i_mem_island_assert.fail_cnt;
    end
    $display("%s: %0d errors", name, err_cnt - test_errs);
    test_errs = err_cnt;
  endtask

  // Narrow responses in request order, wide ones counted against grants
  always @(negedge clk_i) begin
    if (narrow_rvalid_o && exp_q.size() == 0) begin
      $display("Unexpected narrow rvalid at %0t", $time);
      err_cnt++;
    end else if (narrow_rvalid_o) begin
      if (!exp_q[0][32]) begin
        check_narrow(narrow_rdata_o, exp_q[0][31:0]);
      end
      exp_q.delete(0);
    end
    if (wide_rvalid_o) begin
      wide_seen++;
      if (wide_seen > wide_issued) begin
        $display("Unexpected wide rvalid at %0t", $time);
        err_cnt++;
        wide_seen = wide_issued;
      end
    end
  end

  // Narrow grant follows the request in every cycle
  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_grant(narrow_gnt_o, narrow_req_i);
    end
  end

  initial begin
    mem_addr_pkg::addr_t addr;
    logic [31:0] r;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (wide_gnt_o !== 1'b0 || narrow_rvalid_o !== 1'b0 || wide_rvalid_o !== 1'b0) begin
      $display("Wide grant or an rvalid is not low after reset");
      err_cnt++;
    end
    // Preload every word with a pattern unique to its address
    for (int i = 0; i < 4096; i += 4) begin
      narrow_access(i, 1'b1, i * 32'h0100_0193 ^ 32'h5a5a_c3c3, 4'hf);
    end
    narrow_access(32'h10, 1'b1, 32'h1122_3344, 4'b0101);
    narrow_access(32'h14, 1'b1, 32'hdead_beef, 4'b1000);
    narrow_access(32'h10, 1'b0, '0, '0);
    narrow_access(32'h14, 1'b0, '0, '0);
    end_test("reset and byte strobes");

    wide_access(32'h200, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff);
    wide_access(32'h208, 1'b1, 64'hfedc_ba98_7654_3210, 8'h3c);
    for (int a = 32'h200; a < 32'h210; a += 4) begin
      narrow_access(a, 1'b0, '0, '0);
    end
    end_test("wide write, narrow read");

    for (int a = 32'h340; a < 32'h350; a += 4) begin
      narrow_access(a, 1'b1, 32'hc0de_0000 | a, 4'hf);
    end
    narrow_req_i = 1'b0;
    wide_access(32'h340, 1'b0, '0, '0);
    wide_access(32'h34c, 1'b0, '0, '0);
    end_test("narrow write, wide read");

    // Narrow burst holds sub-bank 0 while the wide read waits for it
    fork
      wide_access(32'h120, 1'b0, '0, '0);
      begin
        @(negedge clk_i);
        narrow_access(32'h0120, 1'b1, 32'haabb_ccdd, 4'b0001);
        narrow_access(32'h1120, 1'b1, 32'h1122_3344, 4'b0110);
        narrow_access(32'h2120, 1'b1, 32'h5566_7788, 4'b1000);
        narrow_req_i = 1'b0;
      end
    join
    end_test("contention");

    for (int i = 0; i < 200; i++) begin
      r    = $random(seed);
      addr = $random(seed);
      if (r[0]) begin
        narrow_req_i = 1'b0;
        wide_access(addr, r[1], {$random(seed), $random(seed)}, r[15:8]);
      end else begin
        narrow_access(addr, r[1], $random(seed), r[7:4]);
      end
    end
    end_test("random mix");

    $display("Checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/mem_island_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratchpad port assertions
// Narrow latency and one wide access in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module mem_island_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic narrow_req_i,
  input logic narrow_rvalid_i,
  input logic wide_gnt_i,
  input logic wide_rvalid_i
);

  // High from the granting edge until the response
  logic wide_busy_q;

  int   fail_cnt = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wide_busy_q <= 1'b0;
    end else if (wide_gnt_i) begin
      wide_busy_q <= 1'b1;
    end else if (wide_rvalid_i) begin
      wide_busy_q <= 1'b0;
    end
  end

  narrow_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    narrow_req_i |=> narrow_rvalid_i)
    else begin
      $error("narrow rvalid missing one cycle after a request");
      fail_cnt++;
    end

  wide_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_busy_q |-> !wide_gnt_i)
    else begin
      $error("second wide grant before the wide response");
      fail_cnt++;
    end

  wide_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wide_rvalid_i |=> !wide_rvalid_i)
    else begin
      $error("wide rvalid longer than one cycle");
      fail_cnt++;
    end

endmodule

bind mem_island_top mem_island_assert i_mem_island_assert (
  .clk_i           ( clk_i           ),
  .rst_ni          ( rst_ni          ),
  .narrow_req_i    ( narrow_req_i    ),
  .narrow_rvalid_i ( narrow_rvalid_o ),
  .wide_gnt_i      ( wide_gnt_o      ),
  .wide_rvalid_i   ( wide_rvalid_o   )
);

// ==== src/mem_island_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Banked scratchpad top level
// One narrow 32-bit and one wide 64-bit port sharing
// four SRAM sub-banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "mem_island_consts.svh"

module mem_island_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Narrow port
  input  logic                       narrow_req_i,
  output logic                       narrow_gnt_o,
  input  mem_addr_pkg::addr_t        narrow_addr_i,
  input  logic                       narrow_we_i,
  input  mem_addr_pkg::narrow_data_t narrow_wdata_i,
  input  mem_addr_pkg::narrow_strb_t narrow_strb_i,
  output logic                       narrow_rvalid_o,
  output mem_addr_pkg::narrow_data_t narrow_rdata_o,

  // Wide port
  input  logic                       wide_req_i,
  output logic                       wide_gnt_o,
  input  mem_addr_pkg::addr_t        wide_addr_i,
  input  logic                       wide_we_i,
  input  mem_addr_pkg::wide_data_t   wide_wdata_i,
  input  mem_addr_pkg::wide_strb_t   wide_strb_i,
  output logic                       wide_rvalid_o,
  output mem_addr_pkg::wide_data_t   wide_rdata_o
);

  // One access path per sub-bank for each side
  bank_port_if narrow_if [`NUM_BANKS] ();
  bank_port_if wide_if   [`NUM_BANKS] ();

  narrow_router i_narrow_router (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .narrow_req_i    ( narrow_req_i    ),
    .narrow_addr_i   ( narrow_addr_i   ),
    .narrow_we_i     ( narrow_we_i     ),
    .narrow_wdata_i  ( narrow_wdata_i  ),
    .narrow_strb_i   ( narrow_strb_i   ),
    .narrow_gnt_o    ( narrow_gnt_o    ),
    .narrow_rvalid_o ( narrow_rvalid_o ),
    .narrow_rdata_o  ( narrow_rdata_o  ),
    .bank_port       ( narrow_if       )
  );

  wide_splitter_fsm i_wide_splitter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .wide_req_i    ( wide_req_i    ),
    .wide_addr_i   ( wide_addr_i   ),
    .wide_we_i     ( wide_we_i     ),
    .wide_wdata_i  ( wide_wdata_i  ),
    .wide_strb_i   ( wide_strb_i   ),
    .wide_gnt_o    ( wide_gnt_o    ),
    .wide_rvalid_o ( wide_rvalid_o ),
    .wide_rdata_o  ( wide_rdata_o  ),
    .bank_port     ( wide_if       )
  );

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_bank
    bank_arbiter i_bank_arbiter (
      .clk_i       ( clk_i        ),
      .rst_ni      ( rst_ni       ),
      .narrow_port ( narrow_if[i] ),
      .wide_port   ( wide_if[i]   )
    );
  end

endmodule

// ==== src/wide_splitter_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wide access splitter
// Issues both halves of a wide access and joins the
// two sub-bank responses into one wide response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "mem_island_consts.svh"

module wide_splitter_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wide_req_i,
  input  mem_addr_pkg::addr_t      wide_addr_i,
  input  logic                     wide_we_i,
  input  mem_addr_pkg::wide_data_t wide_wdata_i,
  input  mem_addr_pkg::wide_strb_t wide_strb_i,
  output logic                     wide_gnt_o,
  output logic                     wide_rvalid_o,
  output mem_addr_pkg::wide_data_t wide_rdata_o,
  bank_port_if.master              bank_port [`NUM_BANKS]
);

  localparam int unsigned WBANK_LSB = $clog2(`WIDE_DW/8);
  localparam int unsigned WORD_LSB  = WBANK_LSB + $clog2(`NUM_WIDE_BANKS);

  mem_txn_pkg::wide_state_e   state_q;
  mem_txn_pkg::wide_state_e   state_d;
  mem_txn_pkg::wide_txn_t     txn_q;
  mem_txn_pkg::half_mask_t    issued_q;
  mem_txn_pkg::half_mask_t    returned_q;
  mem_txn_pkg::half_mask_t    half_req;
  mem_txn_pkg::half_mask_t    half_gnt;
  mem_addr_pkg::wide_data_t   rdata_q;
  logic [`NUM_BANKS-1:0]      bank_gnt;
  mem_addr_pkg::narrow_data_t bank_rdata [`NUM_BANKS];
  mem_addr_pkg::narrow_data_t half_rdata [`NW_DIV];

  assign wide_gnt_o = wide_req_i & (state_q == mem_txn_pkg::WIDE_IDLE);

  // Halves still waiting for their sub-bank
  assign half_req = (state_q == mem_txn_pkg::WIDE_ISSUE) ? ~issued_q : '0;

  for (genvar w = 0; w < `NUM_WIDE_BANKS; w++) begin : gen_wide_bank
    for (genvar h = 0; h < `NW_DIV; h++) begin : gen_half
      localparam int unsigned IDX = w * `NW_DIV + h;
      assign bank_port[IDX].req   = half_req[h] & (txn_q.wbank == w);
      assign bank_port[IDX].we    = txn_q.we;
      assign bank_port[IDX].addr  = txn_q.addr;
      assign bank_port[IDX].wdata = txn_q.wdata[h*`NARROW_DW +: `NARROW_DW];
      assign bank_port[IDX].strb  = txn_q.strb[h*(`NARROW_DW/8) +: (`NARROW_DW/8)];
      assign bank_gnt[IDX]        = bank_port[IDX].gnt;
      assign bank_rdata[IDX]      = bank_port[IDX].rdata;
    end
  end

  // Pick out the two sub-banks of the latched wide bank
  always_comb begin
    for (int h = 0; h < `NW_DIV; h++) begin
      half_gnt[h]   = bank_gnt[txn_q.wbank * `NW_DIV + h];
      half_rdata[h] = bank_rdata[txn_q.wbank * `NW_DIV + h];
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_txn_pkg::WIDE_IDLE: begin
        if (wide_req_i) begin
          state_d = mem_txn_pkg::WIDE_ISSUE;
        end
      end
      mem_txn_pkg::WIDE_ISSUE: begin
        // Last half is returned at this edge
        if (&issued_q) begin
          state_d = mem_txn_pkg::WIDE_RESPOND;
        end
      end
      default: state_d = mem_txn_pkg::WIDE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= mem_txn_pkg::WIDE_IDLE;
      issued_q   <= '0;
      returned_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == mem_txn_pkg::WIDE_IDLE) begin
        issued_q   <= '0;
        returned_q <= '0;
      end else begin
        issued_q   <= issued_q | (half_req & half_gnt);
        returned_q <= issued_q;
      end
    end
  end

  // Latch the access and collect each half one cycle after its grant
  always_ff @(posedge clk_i) begin
    if (wide_gnt_o) begin
      txn_q.wbank <= wide_addr_i[WBANK_LSB +: $clog2(`NUM_WIDE_BANKS)];
      txn_q.addr  <= wide_addr_i[WORD_LSB +: `BANK_AW];
      txn_q.we    <= wide_we_i;
      txn_q.wdata <= wide_wdata_i;
      txn_q.strb  <= wide_strb_i;
    end
    for (int h = 0; h < `NW_DIV; h++) begin
      if (issued_q[h] && !returned_q[h]) begin
        rdata_q[h*`NARROW_DW +: `NARROW_DW] <= half_rdata[h];
      end
    end
  end

  assign wide_rvalid_o = (state_q == mem_txn_pkg::WIDE_RESPOND);
  assign wide_rdata_o  = rdata_q;

endmodule

// ==== src/narrow_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Narrow port router
// Decodes the sub-bank, returns data one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "mem_island_consts.svh"

module narrow_router (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       narrow_req_i,
  input  mem_addr_pkg::addr_t        narrow_addr_i,
  input  logic                       narrow_we_i,
  input  mem_addr_pkg::narrow_data_t narrow_wdata_i,
  input  mem_addr_pkg::narrow_strb_t narrow_strb_i,
  output logic                       narrow_gnt_o,
  output logic                       narrow_rvalid_o,
  output mem_addr_pkg::narrow_data_t narrow_rdata_o,
  bank_port_if.master                bank_port [`NUM_BANKS]
);

  // Byte offset, then sub-bank select, then word index
  localparam int unsigned SEL_LSB  = $clog2(`NARROW_DW/8);
  localparam int unsigned WORD_LSB = SEL_LSB + $clog2(`NUM_BANKS);

  mem_addr_pkg::bank_sel_t    sel;
  mem_addr_pkg::bank_sel_t    sel_q;
  logic                       valid_q;
  logic [`NUM_BANKS-1:0]      bank_gnt;
  mem_addr_pkg::narrow_data_t bank_rdata [`NUM_BANKS];

  assign sel = narrow_addr_i[WORD_LSB-1:SEL_LSB];

  for (genvar i = 0; i < `NUM_BANKS; i++) begin : gen_bank
    assign bank_port[i].req   = narrow_req_i & (sel == i);
    assign bank_port[i].we    = narrow_we_i;
    assign bank_port[i].addr  = narrow_addr_i[WORD_LSB +: `BANK_AW];
    assign bank_port[i].wdata = narrow_wdata_i;
    assign bank_port[i].strb  = narrow_strb_i;
    assign bank_gnt[i]        = bank_port[i].gnt;
    assign bank_rdata[i]      = bank_port[i].rdata;
  end

  assign narrow_gnt_o = narrow_req_i & bank_gnt[sel];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= narrow_gnt_o;
    end
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (narrow_gnt_o) begin
      sel_q <= sel;
    end
  end

  assign narrow_rvalid_o = valid_q;
  assign narrow_rdata_o  = bank_rdata[sel_q];

endmodule

// ==== src/bank_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sub-bank arbiter
// Narrow port has fixed priority over the wide port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bank_arbiter (
  input  logic  clk_i,
  input  logic  rst_ni,
  bank_port_if.slave narrow_port,
  bank_port_if.slave wide_port
);

  logic                       bank_req;
  logic                       bank_we;
  mem_addr_pkg::bank_addr_t   bank_addr;
  mem_addr_pkg::narrow_data_t bank_wdata;
  mem_addr_pkg::narrow_strb_t bank_be;
  mem_addr_pkg::narrow_data_t bank_rdata;
  logic                       rd_q;

  // Narrow never waits, wide waits whenever narrow wants this bank
  assign narrow_port.gnt = 1'b1;
  assign wide_port.gnt   = ~narrow_port.req;

  assign bank_req   = narrow_port.req | wide_port.req;
  assign bank_we    = narrow_port.req ? narrow_port.we    : wide_port.we;
  assign bank_addr  = narrow_port.req ? narrow_port.addr  : wide_port.addr;
  assign bank_wdata = narrow_port.req ? narrow_port.wdata : wide_port.wdata;
  assign bank_be    = narrow_port.req ? narrow_port.strb  : wide_port.strb;

  sram_bank i_sram_bank (
    .clk_i   ( clk_i      ),
    .req_i   ( bank_req   ),
    .we_i    ( bank_we    ),
    .addr_i  ( bank_addr  ),
    .wdata_i ( bank_wdata ),
    .be_i    ( bank_be    ),
    .rdata_o ( bank_rdata )
  );

  // A read went into the bank last cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= bank_req & ~bank_we;
    end
  end

  // Same data to both sides, quiet unless a read just completed
  assign narrow_port.rdata = rd_q ? bank_rdata : '0;
  assign wide_port.rdata   = rd_q ? bank_rdata : '0;

endmodule

// ==== src/sram_bank.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scratchpad SRAM sub-bank
// Byte-enabled single port, one-cycle read latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "mem_island_consts.svh"

module sram_bank (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  mem_addr_pkg::bank_addr_t   addr_i,
  input  mem_addr_pkg::narrow_data_t wdata_i,
  input  mem_addr_pkg::narrow_strb_t be_i,
  output mem_addr_pkg::narrow_data_t rdata_o
);

  mem_addr_pkg::narrow_data_t mem_q [`WORDS_PER_BANK];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only enabled bytes change
        for (int b = 0; b < `NARROW_DW/8; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        // Read word lands in the output register
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== src/bank_port_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sub-bank access port
// One requester's req/gnt access to one sub-bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface bank_port_if;

  // Request side
  logic                       req;
  logic                       we;
  mem_addr_pkg::bank_addr_t   addr;
  mem_addr_pkg::narrow_data_t wdata;
  mem_addr_pkg::narrow_strb_t strb;

  // Grant and read data, valid the cycle after req && gnt
  logic                       gnt;
  mem_addr_pkg::narrow_data_t rdata;

  modport master (
    output req, we, addr, wdata, strb,
    input  gnt, rdata
  );

  modport slave (
    input  req, we, addr, wdata, strb,
    output gnt, rdata
  );

endinterface

// ==== src/mem_txn_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wide splitter types
// FSM states and the latched wide access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mem_island_consts.svh"

package mem_txn_pkg;

  typedef enum logic [1:0] {
    WIDE_IDLE,
    WIDE_ISSUE,
    WIDE_RESPOND
  } wide_state_e;

  // One wide access as accepted from the port
  typedef struct packed {
    logic [$clog2(`NUM_WIDE_BANKS)-1:0] wbank;
    mem_addr_pkg::bank_addr_t           addr;
    logic                               we;
    mem_addr_pkg::wide_data_t           wdata;
    mem_addr_pkg::wide_strb_t           strb;
  } wide_txn_t;

  // One bit per sub-bank half of a wide access
  typedef logic [`NW_DIV-1:0] half_mask_t;

endpackage

// ==== src/mem_addr_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory layout types
// Address fields and data words of the scratchpad
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "mem_island_consts.svh"

package mem_addr_pkg;

  // Byte address as seen on both ports
  typedef logic [`ADDR_W-1:0] addr_t;

  // Narrow port payload
  typedef logic [`NARROW_DW-1:0]   narrow_data_t;
  typedef logic [`NARROW_DW/8-1:0] narrow_strb_t;

  // Wide port payload
  typedef logic [`WIDE_DW-1:0]   wide_data_t;
  typedef logic [`WIDE_DW/8-1:0] wide_strb_t;

  // Word index inside one sub-bank
  typedef logic [`BANK_AW-1:0] bank_addr_t;

  // Flat sub-bank index, high bit is the wide bank
  typedef logic [$clog2(`NUM_BANKS)-1:0] bank_sel_t;

endpackage

// ==== src/mem_island_consts.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory island constants
// Widths, bank counts and bank depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MEM_ISLAND_CONSTS_SVH
`define MEM_ISLAND_CONSTS_SVH

// Port widths
`define ADDR_W         32
`define NARROW_DW      32
`define WIDE_DW        64

// Banking: two wide banks of two narrow sub-banks
`define NW_DIV         2
`define NUM_WIDE_BANKS 2
`define NUM_BANKS      4

// Depth of each sub-bank in words
`define WORDS_PER_BANK 256
`define BANK_AW        8

`endif
